/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module bp_tb -f sim.f
	out=$$(./obj_dir/Vbp_tb); echo "$$out"; echo "$$out" | grep -q "PASS: all tests"

clean:
	rm -rf obj_dir

/* branch_buffer/branch_target_buffer.sv */
`timescale 1ns/100ps
`include "bp_cfg.svh"

module branch_target_buffer (
    input  logic                 clk,
    input  logic                 rst,
    input  rv32i_pkg::rv32i_word fetch_pc,
    resolve_if.dst               req,
    lookup_if.src                look
);
    import bp_pkg::*;

    logic         br_exe_hit;     // resolved branch already tracked
    btb_payload_t br_exe_payload; // its current entry
    logic         br_insert;
    logic         br_modify;
    btb_payload_t br_fresh;       // payload for a new branch
    btb_payload_t br_shifted;     // payload after one more outcome
    logic         jp_exe_hit;     // resolved jal already tracked
    logic         jp_insert;
    jtb_payload_t jp_fresh;

    // branch table decisions
    assign br_modify = req.br_valid && br_exe_hit;                // known branch, shift histories
    assign br_insert = req.br_valid && !br_exe_hit && req.taken; // only taken branches enter

    always_comb begin
        br_fresh                                = '0;
        br_fresh.offset                         = req.bimm[12:1];
        br_fresh.branch_hist[`BP_HIST_W-1]      = 1'b1; // seen taken once
    end

    always_comb begin
        br_shifted        = br_exe_payload;
        br_shifted.branch_hist = {req.taken, br_exe_payload.branch_hist[`BP_HIST_W-1:1]};
        // record what we would have predicted for this instance
        br_shifted.pred_hist = {predict_branch(br_exe_payload),
                                br_exe_payload.pred_hist[`BP_HIST_W-1:1]};
    end

    // jump table decisions, jal entries never change once written
    assign jp_insert       = req.jal_valid && !jp_exe_hit && req.taken;
    assign jp_fresh.target = req.target;

    tag_match_table #(
        .payload_t (btb_payload_t),
        .DEPTH     (`BP_BTB_DEPTH)
    ) u_btb (
        .clk            (clk),
        .rst            (rst),
        .exe_pc         (req.pc),
        .fetch_pc       (fetch_pc),
        .insert         (br_insert),
        .insert_payload (br_fresh),
        .modify         (br_modify),
        .modify_payload (br_shifted),
        .exe_hit        (br_exe_hit),
        .exe_payload    (br_exe_payload),
        .fetch_hit      (look.br_hit),
        .fetch_payload  (look.br_payload)
    );

    tag_match_table #(
        .payload_t (jtb_payload_t),
        .DEPTH     (`BP_JTB_DEPTH)
    ) u_jtb (
        .clk            (clk),
        .rst            (rst),
        .exe_pc         (req.pc),
        .fetch_pc       (fetch_pc),
        .insert         (jp_insert),
        .insert_payload (jp_fresh),
        .modify         (1'b0),      // targets are static
        .modify_payload (jp_fresh),
        .exe_hit        (jp_exe_hit),
        .exe_payload    (),          // only the hit matters here
        .fetch_hit      (look.jp_hit),
        .fetch_payload  (look.jp_payload)
    );

endmodule : branch_target_buffer

/* branch_buffer/tag_match_table.sv */
`timescale 1ns/100ps
`include "bp_cfg.svh"

module tag_match_table #(
    parameter type payload_t = logic [31:0],
    parameter int  DEPTH     = `BP_BTB_DEPTH
) (
    input  logic                 clk,
    input  logic                 rst,
    input  rv32i_pkg::rv32i_word exe_pc,         // pc resolved in execute
    input  rv32i_pkg::rv32i_word fetch_pc,       // pc being fetched
    input  logic                 insert,         // write new entry at head
    input  payload_t             insert_payload,
    input  logic                 modify,         // rewrite matching entry
    input  payload_t             modify_payload,
    output logic                 exe_hit,
    output payload_t             exe_payload,
    output logic                 fetch_hit,
    output payload_t             fetch_payload
);
    import rv32i_pkg::*;

    localparam int IDX_W = $clog2(DEPTH);

    logic [DEPTH-1:0] valid;           // entry holds a real pc
    rv32i_word        tags [DEPTH];    // instr pc per entry
    payload_t         payloads [DEPTH];
    logic [IDX_W-1:0] head;            // oldest entry, next to evict
    logic [DEPTH-1:0] exe_match;       // one-hot when the table is consistent
    logic [DEPTH-1:0] fetch_match;
    logic [IDX_W-1:0] exe_idx;
    logic [IDX_W-1:0] fetch_idx;

    // full tag compare on both ports
    for (genvar i = 0; i < DEPTH; i++) begin : g_match
        assign exe_match[i]   = valid[i] && (tags[i] == exe_pc);
        assign fetch_match[i] = valid[i] && (tags[i] == fetch_pc);
    end

    // encode match vectors to an index
    always_comb begin
        exe_idx   = '0;
        fetch_idx = '0;
        for (int i = 0; i < DEPTH; i++) begin
            if (exe_match[i]) exe_idx = IDX_W'(i);
            if (fetch_match[i]) fetch_idx = IDX_W'(i);
        end
    end

    assign exe_hit       = |exe_match;
    assign fetch_hit     = |fetch_match;
    assign exe_payload   = payloads[exe_idx];   // don't care on a miss
    assign fetch_payload = payloads[fetch_idx];

    // control state, fifo replacement
    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
            head  <= '0;
        end else if (insert) begin
            valid[head] <= 1'b1;
            head        <= head + IDX_W'(1); // wraps, depth is a power of two
        end
    end

    // storage, one write per clock
    always_ff @(posedge clk) begin
        if (insert) begin
            tags[head]     <= exe_pc;
            payloads[head] <= insert_payload;
        end else if (modify && exe_hit) begin
            payloads[exe_idx] <= modify_payload; // tag stays
        end
    end

endmodule : tag_match_table

/* common/bp_cfg.svh */
`ifndef BP_CFG_SVH
`define BP_CFG_SVH

// table depths, both powers of two so the fifo heads wrap on their own
`define BP_BTB_DEPTH 32
`define BP_JTB_DEPTH 16

// history register width, bit 9 is the newest outcome
`define BP_HIST_W 10

// prediction thresholds on the branch history
`define BP_HI_THRESH   10'b11_1000_0000
`define BP_LO_THRESH   10'b00_0001_0000
`define BP_MISS_THRESH 10'b11_0101_0000

`define BP_NO_TARGET 32'hffff_ffff // fetch target when nothing is predicted

`endif

/* common/bp_ifc.sv */
`timescale 1ns/100ps

// execute side update request, one cycle strobe
interface resolve_if;
    import rv32i_pkg::*;

    logic      br_valid;  // conditional branch resolved
    logic      jal_valid; // jal resolved
    rv32i_word pc;        // pc of the resolved instr
    logic      taken;     // outcome from execute
    rv32i_word bimm;      // branch immediate
    rv32i_word target;    // computed target

    modport src (
        output br_valid, jal_valid, pc, taken, bimm, target
    );

    modport dst (
        input br_valid, jal_valid, pc, taken, bimm, target
    );
endinterface : resolve_if

// fetch side table lookup, purely combinational
interface lookup_if;
    import bp_pkg::*;

    logic         br_hit;     // fetch pc found in branch table
    btb_payload_t br_payload; // its entry
    logic         jp_hit;     // fetch pc found in jump table
    jtb_payload_t jp_payload; // its entry

    modport src (
        output br_hit, br_payload, jp_hit, jp_payload
    );

    modport dst (
        input br_hit, br_payload, jp_hit, jp_payload
    );
endinterface : lookup_if

/* common/bp_pkg.sv */
`include "bp_cfg.svh"

package bp_pkg;

    // branch table payload, 32 bits in all
    typedef struct packed {
        logic [11:0]            offset;      // bimm[12:1]
        logic [`BP_HIST_W-1:0]  branch_hist; // resolved outcomes, msb newest
        logic [`BP_HIST_W-1:0]  pred_hist;   // our own predictions, msb newest
    } btb_payload_t;

    // jump table payload
    typedef struct packed {
        rv32i_pkg::rv32i_word target; // full jal target
    } jtb_payload_t;

    // taken / not taken from the two histories of one entry
    function automatic logic predict_branch(input btb_payload_t p);
        logic [`BP_HIST_W-1:0] miss; // bits where we guessed wrong
        logic                  result;
        miss = p.branch_hist ^ p.pred_hist;
        if (p.branch_hist >= `BP_HI_THRESH) begin
            result = 1'b1; // taken often and recently
        end else if (p.branch_hist < `BP_LO_THRESH) begin
            result = 1'b0; // practically never taken lately
        end else if (miss >= `BP_MISS_THRESH) begin
            result = ~p.pred_hist[`BP_HIST_W-1]; // recent guesses poor, flip
        end else begin
            result = p.pred_hist[`BP_HIST_W-1]; // keep last guess
        end
        return result;
    endfunction

    // pc plus sign extended bimm
    function automatic rv32i_pkg::rv32i_word branch_target(
        input rv32i_pkg::rv32i_word pc,
        input logic [11:0]          offset
    );
        rv32i_pkg::rv32i_word sext; // offset << 1, sign extended
        sext = {{19{offset[11]}}, offset, 1'b0};
        return pc + sext;
    endfunction

endpackage : bp_pkg

/* common/rv32i_pkg.sv */
package rv32i_pkg;

    // base isa word, used for pcs, immediates and targets
    typedef logic [31:0] rv32i_word;

    // rv32i major opcodes, bits 6:0 of the instruction
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111, // load upper immediate
        op_auipc = 7'b0010111, // add upper immediate to pc
        op_jal   = 7'b1101111, // jump and link
        op_jalr  = 7'b1100111, // jump and link register
        op_br    = 7'b1100011, // conditional branch
        op_load  = 7'b0000011, // loads
        op_store = 7'b0100011, // stores
        op_imm   = 7'b0010011, // alu with immediate
        op_reg   = 7'b0110011, // alu register-register
        op_csr   = 7'b1110011  // system and csr
    } rv32i_opcode;

endpackage : rv32i_pkg

/* sim.f */
+incdir+common
common/rv32i_pkg.sv
common/bp_pkg.sv
common/bp_ifc.sv
src/resolve_decode.sv
branch_buffer/tag_match_table.sv
branch_buffer/branch_target_buffer.sv
src/prediction_select.sv
src/branch_predictor_top.sv
verification/bp_assert.sv
verification/bp_tb.sv

/* src/branch_predictor_top.sv */
`timescale 1ns/100ps

module branch_predictor_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   sel,          // first cycle of instr in exe
    input  rv32i_pkg::rv32i_word   pc_exe,
    input  rv32i_pkg::rv32i_opcode opcode,
    input  logic                   branch_taken,
    input  rv32i_pkg::rv32i_word   pc_target,
    input  rv32i_pkg::rv32i_word   bimm_exe,
    input  rv32i_pkg::rv32i_word   pc_fetch,
    output logic                   prediction,
    output rv32i_pkg::rv32i_word   target
);

    resolve_if req_bus ();  // exe report to tables
    lookup_if  look_bus (); // table hits to fetch logic

    resolve_decode u_decode (
        .sel          (sel),
        .pc_exe       (pc_exe),
        .opcode       (opcode),
        .branch_taken (branch_taken),
        .pc_target    (pc_target),
        .bimm_exe     (bimm_exe),
        .req          (req_bus.src)
    );

    branch_target_buffer u_buffer (
        .clk      (clk),
        .rst      (rst),
        .fetch_pc (pc_fetch),
        .req      (req_bus.dst),
        .look     (look_bus.src)
    );

    prediction_select u_select (
        .fetch_pc   (pc_fetch),
        .look       (look_bus.dst),
        .prediction (prediction),
        .target     (target)
    );

endmodule : branch_predictor_top

/* src/prediction_select.sv */
`timescale 1ns/100ps
`include "bp_cfg.svh"

module prediction_select (
    input  rv32i_pkg::rv32i_word  fetch_pc,
    lookup_if.dst                 look,
    output logic                  prediction, // predicted taken for fetch_pc
    output rv32i_pkg::rv32i_word  target     // where fetch should go next
);
    import bp_pkg::*;
    import rv32i_pkg::*;

    logic      br_pred;   // branch rule applied to the hit entry
    rv32i_word br_dest;   // branch destination from the stored offset

    assign br_pred = predict_branch(look.br_payload);
    assign br_dest = branch_target(fetch_pc, look.br_payload.offset);

    // branch table wins over jump table
    always_comb begin
        prediction = 1'b0;
        target     = `BP_NO_TARGET; // invalid unless something is predicted
        if (look.br_hit) begin
            prediction = br_pred;
            if (br_pred) begin
                target = br_dest;
            end
        end else if (look.jp_hit) begin
            prediction = 1'b1;                  // jal is unconditional
            target     = look.jp_payload.target;
        end
    end

endmodule : prediction_select

/* src/resolve_decode.sv */
`timescale 1ns/100ps

module resolve_decode (
    input  logic                   sel,          // first exe cycle of the instr
    input  rv32i_pkg::rv32i_word   pc_exe,
    input  rv32i_pkg::rv32i_opcode opcode,
    input  logic                   branch_taken,
    input  rv32i_pkg::rv32i_word   pc_target,
    input  rv32i_pkg::rv32i_word   bimm_exe,
    resolve_if.src                 req
);
    import rv32i_pkg::*;

    logic is_br;  // opcode is a conditional branch
    logic is_jal; // opcode is jal

    assign is_br  = (opcode == op_br);
    assign is_jal = (opcode == op_jal); // jalr deliberately not tracked

    // only a selected cycle may raise a request, stalls repeat the instr with sel low
    always_comb begin
        req.br_valid  = 1'b0;
        req.jal_valid = 1'b0;
        if (sel) begin
            req.br_valid  = is_br;
            req.jal_valid = is_jal;
        end
    end

    // payload copied regardless, qualified by the valid bits
    assign req.pc     = pc_exe;
    assign req.taken  = branch_taken;
    assign req.bimm   = bimm_exe;
    assign req.target = pc_target;

endmodule : resolve_decode

/* verification/bp_assert.sv */
`timescale 1ns/100ps
`include "bp_cfg.svh"

module bp_assert #(
    parameter int W = 1 // width of the match vectors
) (
    input logic                 clk,
    input logic                 rst,
    input logic [W-1:0]         exe_match,
    input logic [W-1:0]         fetch_match,
    input logic                 prediction,
    input rv32i_pkg::rv32i_word target
);
    int unsigned fail_count = 0; // summed by the testbench

    a_exe_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(exe_match))
        else begin $error("execute pc matches more than one entry"); fail_count++; end

    a_fetch_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(fetch_match))
        else begin $error("fetch pc matches more than one entry"); fail_count++; end

    a_no_target: assert property (@(posedge clk) !prediction |-> target == `BP_NO_TARGET)
        else begin $error("target set while prediction is low"); fail_count++; end

    a_reset_quiet: assert property (@(posedge clk) rst |=> !prediction)
        else begin $error("prediction high right after reset"); fail_count++; end
endmodule : bp_assert

bind tag_match_table bp_assert #(.W(DEPTH)) u_tbl_assert (
    .clk(clk), .rst(rst), .exe_match(exe_match), .fetch_match(fetch_match),
    .prediction(1'b0), .target(`BP_NO_TARGET)
);

bind branch_predictor_top bp_assert #(.W(1)) u_top_assert (
    .clk(clk), .rst(rst), .exe_match(1'b0), .fetch_match(1'b0),
    .prediction(prediction), .target(target)
);

/* verification/bp_tb.sv */
`timescale 1ns/100ps

// free running testbench clock, 8 ns period
module tb_clock (
    output logic clk
);
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk; // half period
    end
endmodule : tb_clock

// compares dut outputs with the expected columns of the current vector
module bp_checker (
    input  logic                 clk,
    input  logic                 check_en,   // a vector is being applied
    input  int                   test_num,
    input  rv32i_pkg::rv32i_word pc_fetch,
    input  logic                 exp_pred,
    input  rv32i_pkg::rv32i_word exp_target,
    input  logic                 prediction,
    input  rv32i_pkg::rv32i_word target,
    output int                   errors
);
    initial errors = 0;

    // outputs are settled half a cycle after the drive edge
    always @(negedge clk) begin
        if (check_en) begin
            if (prediction !== exp_pred) begin
                $display("FAILED test %0d prediction at pc %h: expected %0b actual %0b",
                         test_num, pc_fetch, exp_pred, prediction);
                errors = errors + 1;
            end
            if (target !== exp_target) begin
                $display("FAILED test %0d target at pc %h: expected %h actual %h",
                         test_num, pc_fetch, exp_target, target);
                errors = errors + 1;
            end
        end
    end
endmodule : bp_checker

module bp_tb;
    import rv32i_pkg::*;

    localparam int MAX_LINES   = 400; // read loop bound
    localparam int MIN_VECTORS = 81;  // fewer means a truncated file

    logic        clk;
    logic        rst;
    logic        sel;
    rv32i_opcode opcode;
    rv32i_word   pc_exe;
    logic        branch_taken;
    rv32i_word   pc_target;
    rv32i_word   bimm_exe;
    rv32i_word   pc_fetch;
    logic        prediction;
    rv32i_word   target;

    logic        check_en;
    int          test_num;
    logic        exp_pred;
    rv32i_word   exp_target;
    int          chk_errors;  // value mismatches from the checker
    int          run_errors;  // file and timeout problems
    int          asrt_errors; // assertion failures
    int          total_errors;

    int          fd;
    int          rc;
    int          n_fld;
    int          n_lines;
    int          n_vec;
    string       line;
    int          v_test;
    logic [31:0] v_sel, v_op, v_pc_exe, v_taken, v_tgt, v_bimm, v_fetch, v_pred, v_exp_tgt;

    tb_clock u_clock (.clk(clk));

    branch_predictor_top UUT (
        .clk          (clk),
        .rst          (rst),
        .sel          (sel),
        .pc_exe       (pc_exe),
        .opcode       (opcode),
        .branch_taken (branch_taken),
        .pc_target    (pc_target),
        .bimm_exe     (bimm_exe),
        .pc_fetch     (pc_fetch),
        .prediction   (prediction),
        .target       (target)
    );

    bp_checker u_checker (
        .clk        (clk),
        .check_en   (check_en),
        .test_num   (test_num),
        .pc_fetch   (pc_fetch),
        .exp_pred   (exp_pred),
        .exp_target (exp_target),
        .prediction (prediction),
        .target     (target),
        .errors     (chk_errors)
    );

    initial begin
        rst          = 1'b1;
        sel          = 1'b0;
        opcode       = op_imm;
        pc_exe       = '0;
        branch_taken = 1'b0;
        pc_target    = '0;
        bimm_exe     = '0;
        pc_fetch     = '0;
        check_en     = 1'b0;
        test_num     = 0;
        exp_pred     = 1'b0;
        exp_target   = 32'hffff_ffff;
        run_errors   = 0;
        n_lines      = 0;
        n_vec        = 0;

        repeat (8) @(posedge clk); // reset held for 8 cycles
        rst <= 1'b0;

        fd = $fopen("verification/bp_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open verification/bp_vectors.txt");
            run_errors++;
        end else begin
            while (!$feof(fd) && n_lines < MAX_LINES) begin
                rc = $fgets(line, fd);
                n_lines++;
                if (rc == 0 || line.len() < 2 || line.getc(0) == 8'h23) continue; // '#' lines
                n_fld = $sscanf(line, "%d %h %h %h %h %h %h %h %h %h", v_test, v_sel, v_op,
                                v_pc_exe, v_taken, v_tgt, v_bimm, v_fetch, v_pred, v_exp_tgt);
                if (n_fld != 10) begin
                    $display("vector line %0d is malformed, %0d fields read", n_lines, n_fld);
                    run_errors++;
                    continue;
                end
                @(posedge clk);
                sel          <= v_sel[0];
                opcode       <= rv32i_opcode'(v_op[6:0]);
                pc_exe       <= v_pc_exe;
                branch_taken <= v_taken[0];
                pc_target    <= v_tgt;
                bimm_exe     <= v_bimm;
                pc_fetch     <= v_fetch;
                test_num     <= v_test;
                exp_pred     <= v_pred[0];
                exp_target   <= v_exp_tgt;
                check_en     <= 1'b1;
                n_vec++;
            end
            if (!$feof(fd)) begin
                $display("vector read loop timed out after %0d lines", n_lines);
                run_errors++;
            end
            $fclose(fd);
        end

        if (n_vec < MIN_VECTORS) begin
            $display("vector file is short, %0d vectors read, %0d expected at least",
                     n_vec, MIN_VECTORS);
            run_errors++;
        end

        @(posedge clk); // last vector checked on the negedge before this
        sel        <= 1'b0;
        pc_fetch   <= 32'h0000_0210; // jal of test 2, still held in the jump table
        test_num   <= 7;
        exp_pred   <= 1'b1;
        exp_target <= 32'h0000_1210;
        rst        <= 1'b1;          // reset with the tables populated
        @(posedge clk);
        exp_pred   <= 1'b0;          // every entry invalid once reset is seen
        exp_target <= 32'hffff_ffff;
        @(posedge clk);
        rst      <= 1'b0;
        check_en <= 1'b0;
        @(posedge clk);

        asrt_errors = UUT.u_top_assert.fail_count + UUT.u_buffer.u_btb.u_tbl_assert.fail_count
                    + UUT.u_buffer.u_jtb.u_tbl_assert.fail_count;
        total_errors = chk_errors + run_errors + asrt_errors;
        $display("errors: %0d compare, %0d run, %0d assertion, %0d vectors applied",
                 chk_errors, run_errors, asrt_errors, n_vec);
        if (total_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule : bp_tb

/* verification/bp_vectors.txt */
# test sel opcode pc_exe taken pc_target bimm_exe pc_fetch exp_prediction exp_target
# test is decimal, all other fields hex; one line per clock cycle
1 0 13 00000000 0 00000000 00000000 00000000 0 ffffffff
1 0 13 00000000 0 00000000 00000000 00001000 0 ffffffff
2 1 6f 00000100 1 00000400 00000000 00000100 0 ffffffff
2 0 13 00000000 0 00000000 00000000 00000100 1 00000400
2 1 6f 00000100 1 00000400 00000000 00000100 1 00000400
2 1 6f 00000210 1 00001210 00000000 00000100 1 00000400
2 1 6f 00000220 1 00001220 00000000 00000100 1 00000400
2 1 6f 00000230 1 00001230 00000000 00000100 1 00000400
2 1 6f 00000240 1 00001240 00000000 00000100 1 00000400
2 1 6f 00000250 1 00001250 00000000 00000100 1 00000400
2 1 6f 00000260 1 00001260 00000000 00000100 1 00000400
2 1 6f 00000270 1 00001270 00000000 00000100 1 00000400
2 1 6f 00000280 1 00001280 00000000 00000100 1 00000400
2 1 6f 00000290 1 00001290 00000000 00000100 1 00000400
2 1 6f 000002a0 1 000012a0 00000000 00000100 1 00000400
2 1 6f 000002b0 1 000012b0 00000000 00000100 1 00000400
2 1 6f 000002c0 1 000012c0 00000000 00000100 1 00000400
2 1 6f 000002d0 1 000012d0 00000000 00000100 1 00000400
2 1 6f 000002e0 1 000012e0 00000000 00000100 1 00000400
2 1 6f 000002f0 1 000012f0 00000000 00000100 1 00000400
2 1 6f 00000300 1 00001300 00000000 00000100 1 00000400
2 0 13 00000000 0 00000000 00000000 00000100 0 ffffffff
2 0 13 00000000 0 00000000 00000000 00000300 1 00001300
3 1 63 00000500 1 00000540 00000040 00000500 0 ffffffff
3 1 63 00000500 1 00000540 00000040 00000500 0 ffffffff
3 1 63 00000500 1 00000540 00000040 00000500 0 ffffffff
3 1 63 00000500 1 00000540 00000040 00000500 1 00000540
3 0 13 00000000 0 00000000 00000000 00000500 1 00000540
3 1 63 00000600 0 00000604 00000040 00000600 0 ffffffff
3 0 13 00000000 0 00000000 00000000 00000600 0 ffffffff
4 1 63 00000500 0 00000504 00000040 00000500 1 00000540
4 1 63 00000500 0 00000504 00000040 00000500 1 00000540
4 1 63 00000500 0 00000504 00000040 00000500 0 ffffffff
4 1 63 00000500 0 00000504 00000040 00000500 0 ffffffff
4 1 63 00000500 0 00000504 00000040 00000500 0 ffffffff
4 1 63 00000500 0 00000504 00000040 00000500 0 ffffffff
4 0 13 00000000 0 00000000 00000000 00000500 0 ffffffff
5 1 63 00001000 1 00001040 00000040 00001000 0 ffffffff
5 1 63 00001000 1 00001040 00000040 00001000 0 ffffffff
5 1 63 00001000 1 00001040 00000040 00001000 0 ffffffff
5 1 63 00001000 1 00001040 00000040 00001000 1 00001040
5 1 63 00001004 1 00001044 00000040 00001000 1 00001040
5 1 63 00001008 1 00001048 00000040 00001000 1 00001040
5 1 63 0000100c 1 0000104c 00000040 00001000 1 00001040
5 1 63 00001010 1 00001050 00000040 00001000 1 00001040
5 1 63 00001014 1 00001054 00000040 00001000 1 00001040
5 1 63 00001018 1 00001058 00000040 00001000 1 00001040
5 1 63 0000101c 1 0000105c 00000040 00001000 1 00001040
5 1 63 00001020 1 00001060 00000040 00001000 1 00001040
5 1 63 00001024 1 00001064 00000040 00001000 1 00001040
5 1 63 00001028 1 00001068 00000040 00001000 1 00001040
5 1 63 0000102c 1 0000106c 00000040 00001000 1 00001040
5 1 63 00001030 1 00001070 00000040 00001000 1 00001040
5 1 63 00001034 1 00001074 00000040 00001000 1 00001040
5 1 63 00001038 1 00001078 00000040 00001000 1 00001040
5 1 63 0000103c 1 0000107c 00000040 00001000 1 00001040
5 1 63 00001040 1 00001080 00000040 00001000 1 00001040
5 1 63 00001044 1 00001084 00000040 00001000 1 00001040
5 1 63 00001048 1 00001088 00000040 00001000 1 00001040
5 1 63 0000104c 1 0000108c 00000040 00001000 1 00001040
5 1 63 00001050 1 00001090 00000040 00001000 1 00001040
5 1 63 00001054 1 00001094 00000040 00001000 1 00001040
5 1 63 00001058 1 00001098 00000040 00001000 1 00001040
5 1 63 0000105c 1 0000109c 00000040 00001000 1 00001040
5 1 63 00001060 1 000010a0 00000040 00001000 1 00001040
5 1 63 00001064 1 000010a4 00000040 00001000 1 00001040
5 1 63 00001068 1 000010a8 00000040 00001000 1 00001040
5 1 63 0000106c 1 000010ac 00000040 00001000 1 00001040
5 1 63 00001070 1 000010b0 00000040 00001000 1 00001040
5 1 63 00001074 1 000010b4 00000040 00001000 1 00001040
5 1 63 00001078 1 000010b8 00000040 00001000 1 00001040
5 1 63 0000107c 1 000010bc 00000040 00001000 1 00001040
5 1 63 00001080 1 000010c0 00000040 00001000 1 00001040
5 1 63 00001080 1 000010c0 00000040 00001000 0 ffffffff
5 1 63 00001080 1 000010c0 00000040 00001080 0 ffffffff
5 1 63 00001080 1 000010c0 00000040 00001080 1 000010c0
6 0 6f 00000700 1 00000900 00000000 00000700 0 ffffffff
6 0 13 00000000 0 00000000 00000000 00000700 0 ffffffff
6 1 67 00000710 1 00000a00 00000000 00000710 0 ffffffff
6 0 13 00000000 0 00000000 00000000 00000710 0 ffffffff
6 1 63 00000300 1 00000340 00000040 00000300 1 00001300
6 0 13 00000000 0 00000000 00000000 00000300 0 ffffffff
